// ==== rtl/bus_map_pkg.sv ====
/* Register map of the board control hub: settings and readback addresses,
   reset values, compatibility number and settings bus types */
`default_nettype none

package bus_map_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   // Settings write bus, one strobe per write
   typedef struct packed {
      logic      stb;
      reg_addr_t addr;
      reg_data_t data;
   } set_bus_t;

   // ------------------------------------------------------------
   // Settings addresses
   localparam reg_addr_t SR_LEDS        = 8'd0;
   localparam reg_addr_t SR_SW_RST      = 8'd1;
   localparam reg_addr_t SR_CLOCK_CTRL  = 8'd2;
   localparam reg_addr_t SR_DEVICE_ID   = 8'd3;
   localparam reg_addr_t SR_REF_FREQ    = 8'd4;
   localparam reg_addr_t SR_SFPP_CTRL0  = 8'd8;
   localparam reg_addr_t SR_SFPP_CTRL1  = 8'd9;
   localparam reg_addr_t SR_FP_GPIO_SRC = 8'd72;

   // ------------------------------------------------------------
   // Readback addresses
   localparam reg_addr_t RB_COUNTER      = 8'd0;
   localparam reg_addr_t RB_CLK_STATUS   = 8'd3;
   localparam reg_addr_t RB_COMPAT_NUM   = 8'd6;
   localparam reg_addr_t RB_SFPP_STATUS0 = 8'd8;
   localparam reg_addr_t RB_SFPP_STATUS1 = 8'd9;
   localparam reg_addr_t RB_FP_GPIO_SRC  = 8'd13;
   localparam reg_addr_t RB_DEVICE_ID    = 8'd14;
   localparam reg_addr_t RB_TIME_LO      = 8'd100;
   localparam reg_addr_t RB_TIME_HI      = 8'd104;
   localparam reg_addr_t RB_PPS_LO       = 8'd120;
   localparam reg_addr_t RB_PPS_HI       = 8'd124;

   // Bit 6 enables the GPSDO by default
   localparam logic [7:0]  CLOCK_CTRL_RESET = 8'h40;
   // 10 MHz reference
   localparam reg_data_t   REF_FREQ_RESET   = 32'd10_000_000;
   localparam logic [15:0] COMPAT_MAJOR     = 16'h0027;
   localparam logic [15:0] COMPAT_MINOR     = 16'h0002;

endpackage

`default_nettype wire

// ==== rtl/board_status_pkg.sv ====
/* Board status types: SFP cage pins, SFP status word and time */
`default_nettype none

package board_status_pkg;

   // Module pins of one SFP cage
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // Sticky change flags above the current pin levels
   typedef struct packed {
      sfp_pins_t changed;
      sfp_pins_t now;
   } sfp_status_t;

   typedef logic [63:0] time_t;

endpackage

`default_nettype wire

// ==== rtl/axil_bus_fsm.sv ====
/* AXI4-Lite slave that turns host writes into settings strobes and
   host reads into readback strobes with a captured response word */
`default_nettype none

module axil_bus_fsm import bus_map_pkg::*; (
   input  wire              clk,
   input  wire              i_reset,
   // AXI4-Lite slave
   input  wire reg_addr_t   i_awaddr,
   input  wire              i_awvalid,
   output logic             o_awready,
   input  wire reg_data_t   i_wdata,
   input  wire              i_wvalid,
   output logic             o_wready,
   output logic             o_bvalid,
   input  wire              i_bready,
   output logic [1:0]       o_bresp,
   input  wire reg_addr_t   i_araddr,
   input  wire              i_arvalid,
   output logic             o_arready,
   output logic             o_rvalid,
   input  wire              i_rready,
   output logic [31:0]      o_rdata,
   output logic [1:0]       o_rresp,
   // Internal settings and readback buses
   output set_bus_t         o_set,
   output reg_addr_t        o_rb_addr,
   output logic             o_rb_rd_stb,
   input  wire reg_data_t   i_rb_data
);

   typedef enum logic [2:0] {IDLE, WRITE, WRESP, READ, RRESP} state_t;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   state_t    state;
   logic      wr_pending;
   logic      wr_accept;
   logic      rd_accept;
   logic      set_stb;
   reg_addr_t set_addr;
   reg_data_t set_data;
   reg_data_t rdata;

   // Write wins when both channels are offered together
   assign wr_pending = i_awvalid && i_wvalid;
   assign wr_accept  = (state == IDLE) && wr_pending;
   assign rd_accept  = (state == IDLE) && i_arvalid && !wr_pending;

   assign o_awready = wr_accept;
   assign o_wready  = wr_accept;
   assign o_arready = rd_accept;
   assign o_bresp   = RESP_OKAY;
   assign o_rresp   = RESP_OKAY;
   assign o_rdata   = rdata;
   assign o_set     = '{stb: set_stb, addr: set_addr, data: set_data};

   // ------------------------------------------------------------
   // Control state
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state       <= IDLE;
         set_stb     <= 1'b0;
         o_rb_rd_stb <= 1'b0;
         o_bvalid    <= 1'b0;
         o_rvalid    <= 1'b0;
      end else begin
         set_stb     <= 1'b0;
         o_rb_rd_stb <= 1'b0;
         case (state)
            IDLE: begin
               if (wr_accept)
                  state <= WRITE;
               else if (rd_accept)
                  state <= READ;
            end
            WRITE: begin
               set_stb <= 1'b1;
               state   <= WRESP;
            end
            WRESP: begin
               // Register takes the write on the same edge as bvalid
               if (set_stb)
                  o_bvalid <= 1'b1;
               else if (o_bvalid && i_bready) begin
                  o_bvalid <= 1'b0;
                  state    <= IDLE;
               end
            end
            READ: begin
               o_rb_rd_stb <= 1'b1;
               state       <= RRESP;
            end
            RRESP: begin
               if (o_rb_rd_stb)
                  o_rvalid <= 1'b1;
               else if (o_rvalid && i_rready) begin
                  o_rvalid <= 1'b0;
                  state    <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Address, data and the captured readback word
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         set_addr <= i_awaddr;
         set_data <= i_wdata;
      end
      if (rd_accept)
         o_rb_addr <= i_araddr;
      if ((state == RRESP) && o_rb_rd_stb)
         rdata <= i_rb_data;
   end

endmodule

`default_nettype wire

// ==== rtl/timekeeper.sv ====
/* Free-running counter and 64-bit time, with the time captured on each
   rising edge of the synchronized PPS input */
`default_nettype none

module timekeeper import bus_map_pkg::*, board_status_pkg::*; #(
   parameter int SYNC_STAGES = 2
) (
   input  wire         clk,
   input  wire         i_reset,
   input  wire         i_pps,
   output reg_data_t   o_counter,
   output time_t       o_time,
   output time_t       o_last_pps
);

   logic [SYNC_STAGES-1:0] pps_sync;
   logic                   pps_prev;
   logic                   pps_edge;

   // PPS comes from the board connector and is asynchronous to clk
   always_ff @(posedge clk) begin
      pps_sync <= {pps_sync[SYNC_STAGES-2:0], i_pps};
      pps_prev <= pps_sync[SYNC_STAGES-1];
   end

   assign pps_edge = pps_sync[SYNC_STAGES-1] && !pps_prev;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_counter  <= '0;
         o_time     <= '0;
         o_last_pps <= '0;
      end else begin
         o_counter <= o_counter + 32'd1;
         o_time    <= o_time + 64'd1;
         if (pps_edge)
            o_last_pps <= o_time;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/setting_regs.sv ====
/* Board setting registers loaded from the settings bus, with a one-cycle
   pulse when the reference frequency is written */
`default_nettype none

module setting_regs import bus_map_pkg::*; (
   input  wire              clk,
   input  wire              i_reset,
   input  wire set_bus_t    i_set,
   output logic [1:0]       o_leds,
   // Bits: PHY, radio domain, radio PLL, ADC idelay control
   output logic [3:0]       o_sw_rst,
   output logic [7:0]       o_clock_control,
   output logic [15:0]      o_device_id,
   output reg_data_t        o_ref_freq,
   output logic             o_ref_freq_changed,
   output logic [1:0]       o_sfp0_rs_drive_low,
   output logic [1:0]       o_sfp1_rs_drive_low,
   // Two bits per front-panel pin
   output logic [23:0]      o_fp_gpio_src
);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_leds              <= '0;
         o_sw_rst            <= '0;
         o_clock_control     <= CLOCK_CTRL_RESET;
         o_device_id         <= '0;
         o_ref_freq          <= REF_FREQ_RESET;
         o_ref_freq_changed  <= 1'b0;
         o_sfp0_rs_drive_low <= '0;
         o_sfp1_rs_drive_low <= '0;
         o_fp_gpio_src       <= '0;
      end else begin
         o_ref_freq_changed <= i_set.stb && (i_set.addr == SR_REF_FREQ);
         if (i_set.stb) begin
            // Unmapped addresses fall through untouched
            case (i_set.addr)
               SR_LEDS:        o_leds              <= i_set.data[1:0];
               SR_SW_RST:      o_sw_rst            <= i_set.data[3:0];
               SR_CLOCK_CTRL:  o_clock_control     <= i_set.data[7:0];
               SR_DEVICE_ID:   o_device_id         <= i_set.data[15:0];
               SR_REF_FREQ:    o_ref_freq          <= i_set.data;
               SR_SFPP_CTRL0:  o_sfp0_rs_drive_low <= i_set.data[1:0];
               SR_SFPP_CTRL1:  o_sfp1_rs_drive_low <= i_set.data[1:0];
               SR_FP_GPIO_SRC: o_fp_gpio_src       <= i_set.data[23:0];
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/sfp_status.sv ====
/* SFP cage pin synchronizers with sticky change flags, cleared when
   the host reads the cage's status word */
`default_nettype none

module sfp_status import bus_map_pkg::*, board_status_pkg::*; #(
   parameter int SYNC_STAGES = 2
) (
   input  wire               clk,
   input  wire               i_reset,
   input  wire sfp_pins_t    i_sfp0_pins,
   input  wire sfp_pins_t    i_sfp1_pins,
   input  wire reg_addr_t    i_rb_addr,
   input  wire               i_rb_rd_stb,
   output sfp_status_t       o_sfp0_status,
   output sfp_status_t       o_sfp1_status
);

   sfp_pins_t   cage_pins   [2];
   sfp_status_t cage_status [2];

   assign cage_pins[0]  = i_sfp0_pins;
   assign cage_pins[1]  = i_sfp1_pins;
   assign o_sfp0_status = cage_status[0];
   assign o_sfp1_status = cage_status[1];

   for (genvar g = 0; g < 2; g++) begin : g_cage
      localparam reg_addr_t STATUS_ADDR = (g == 0) ? RB_SFPP_STATUS0 : RB_SFPP_STATUS1;

      sfp_pins_t sync_q [SYNC_STAGES];
      sfp_pins_t prev_q;
      sfp_pins_t changed_q;
      logic      clear;

      // ------------------------------------------------------------
      // Synchronizer chain and previous level
      always_ff @(posedge clk) begin
         sync_q[0] <= cage_pins[g];
         for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
         prev_q <= sync_q[SYNC_STAGES-1];
      end

      assign clear = i_rb_rd_stb && (i_rb_addr == STATUS_ADDR);

      // Sticky flags, a read of the status word wins over a new change
      always_ff @(posedge clk) begin
         if (i_reset || clear)
            changed_q <= '0;
         else
            changed_q <= changed_q | (sync_q[SYNC_STAGES-1] ^ prev_q);
      end

      assign cage_status[g] = '{changed: changed_q, now: sync_q[SYNC_STAGES-1]};
   end

endmodule

`default_nettype wire

// ==== rtl/readback_mux.sv ====
/* Readback word selection by address, holding the high time words that
   a read of the matching low word latches */
`default_nettype none

module readback_mux import bus_map_pkg::*, board_status_pkg::*; (
   input  wire               clk,
   input  wire               i_reset,
   input  wire reg_addr_t    i_rb_addr,
   input  wire               i_rb_rd_stb,
   input  wire reg_data_t    i_counter,
   input  wire time_t        i_time,
   input  wire time_t        i_last_pps,
   input  wire [7:0]         i_clock_status,
   input  wire sfp_status_t  i_sfp0_status,
   input  wire sfp_status_t  i_sfp1_status,
   input  wire [15:0]        i_device_id,
   input  wire [23:0]        i_fp_gpio_src,
   output reg_data_t         o_rb_data
);

   reg_data_t time_hi_q;
   reg_data_t pps_hi_q;

   // High word is held so the 64-bit value reads back as one snapshot
   always_ff @(posedge clk) begin
      if (i_reset) begin
         time_hi_q <= '0;
         pps_hi_q  <= '0;
      end else if (i_rb_rd_stb) begin
         if (i_rb_addr == RB_TIME_LO)
            time_hi_q <= i_time[63:32];
         if (i_rb_addr == RB_PPS_LO)
            pps_hi_q <= i_last_pps[63:32];
      end
   end

   // ------------------------------------------------------------
   // Word select
   always_comb begin
      case (i_rb_addr)
         RB_COUNTER:      o_rb_data = i_counter;
         RB_CLK_STATUS:   o_rb_data = {24'd0, i_clock_status};
         RB_COMPAT_NUM:   o_rb_data = {COMPAT_MAJOR, COMPAT_MINOR};
         RB_SFPP_STATUS0: o_rb_data = {26'd0, i_sfp0_status};
         RB_SFPP_STATUS1: o_rb_data = {26'd0, i_sfp1_status};
         RB_FP_GPIO_SRC:  o_rb_data = {8'd0, i_fp_gpio_src};
         RB_DEVICE_ID:    o_rb_data = {16'd0, i_device_id};
         RB_TIME_LO:      o_rb_data = i_time[31:0];
         RB_TIME_HI:      o_rb_data = time_hi_q;
         RB_PPS_LO:       o_rb_data = i_last_pps[31:0];
         RB_PPS_HI:       o_rb_data = pps_hi_q;
         default:         o_rb_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/ctrl_bus_top.sv ====
/* Board control hub: AXI4-Lite host port, setting registers, SFP status
   and timekeeping */
`default_nettype none

module ctrl_bus_top import bus_map_pkg::*, board_status_pkg::*; #(
   parameter int SYNC_STAGES = 2
) (
   input  wire              clk,
   input  wire              i_reset,
   // AXI4-Lite host port
   input  wire reg_addr_t   i_awaddr,
   input  wire              i_awvalid,
   output logic             o_awready,
   input  wire reg_data_t   i_wdata,
   input  wire              i_wvalid,
   output logic             o_wready,
   output logic             o_bvalid,
   input  wire              i_bready,
   output logic [1:0]       o_bresp,
   input  wire reg_addr_t   i_araddr,
   input  wire              i_arvalid,
   output logic             o_arready,
   output logic             o_rvalid,
   input  wire              i_rready,
   output logic [31:0]      o_rdata,
   output logic [1:0]       o_rresp,
   // Board signals
   input  wire              i_pps,
   input  wire [7:0]        i_clock_status,
   input  wire sfp_pins_t   i_sfp0_pins,
   input  wire sfp_pins_t   i_sfp1_pins,
   output logic [1:0]       o_leds,
   output logic [3:0]       o_sw_rst,
   output logic [7:0]       o_clock_control,
   output reg_data_t        o_ref_freq,
   output logic             o_ref_freq_changed,
   output logic [1:0]       o_sfp0_rs_drive_low,
   output logic [1:0]       o_sfp1_rs_drive_low,
   output logic [23:0]      o_fp_gpio_src
);

   set_bus_t    set_bus;
   reg_addr_t   rb_addr;
   logic        rb_rd_stb;
   reg_data_t   rb_data;
   reg_data_t   counter;
   time_t       cur_time;
   time_t       last_pps;
   sfp_status_t sfp0_status;
   sfp_status_t sfp1_status;
   logic [15:0] device_id;

   axil_bus_fsm u_bus_fsm (
      .clk(clk), .i_reset(i_reset),
      .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
      .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
      .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
      .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
      .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
      .o_set(set_bus), .o_rb_addr(rb_addr), .o_rb_rd_stb(rb_rd_stb), .i_rb_data(rb_data)
   );

   setting_regs u_setting_regs (
      .clk(clk), .i_reset(i_reset), .i_set(set_bus),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control),
      .o_device_id(device_id), .o_ref_freq(o_ref_freq),
      .o_ref_freq_changed(o_ref_freq_changed),
      .o_sfp0_rs_drive_low(o_sfp0_rs_drive_low), .o_sfp1_rs_drive_low(o_sfp1_rs_drive_low),
      .o_fp_gpio_src(o_fp_gpio_src)
   );

   sfp_status #(.SYNC_STAGES(SYNC_STAGES)) u_sfp_status (
      .clk(clk), .i_reset(i_reset),
      .i_sfp0_pins(i_sfp0_pins), .i_sfp1_pins(i_sfp1_pins),
      .i_rb_addr(rb_addr), .i_rb_rd_stb(rb_rd_stb),
      .o_sfp0_status(sfp0_status), .o_sfp1_status(sfp1_status)
   );

   timekeeper #(.SYNC_STAGES(SYNC_STAGES)) u_timekeeper (
      .clk(clk), .i_reset(i_reset), .i_pps(i_pps),
      .o_counter(counter), .o_time(cur_time), .o_last_pps(last_pps)
   );

   readback_mux u_readback_mux (
      .clk(clk), .i_reset(i_reset),
      .i_rb_addr(rb_addr), .i_rb_rd_stb(rb_rd_stb),
      .i_counter(counter), .i_time(cur_time), .i_last_pps(last_pps),
      .i_clock_status(i_clock_status),
      .i_sfp0_status(sfp0_status), .i_sfp1_status(sfp1_status),
      .i_device_id(device_id), .i_fp_gpio_src(o_fp_gpio_src),
      .o_rb_data(rb_data)
   );

endmodule

`default_nettype wire

// ==== testbench/ctrl_bus_tb.sv ====
/* Testbench for the board control hub: AXI4-Lite register accesses,
   SFP sticky flags, timekeeping and response back-pressure */
`default_nettype none

module ctrl_bus_tb
   import bus_map_pkg::*, board_status_pkg::*;
();

   localparam int SYNC_STAGES = 3;
   localparam int DRIVE_DELAY = 10;
   localparam int TIMEOUT     = 64;

   logic        clk;
   logic        i_reset;
   reg_addr_t   i_awaddr;
   logic        i_awvalid;
   logic        o_awready;
   reg_data_t   i_wdata;
   logic        i_wvalid;
   logic        o_wready;
   logic        o_bvalid;
   logic        i_bready;
   logic [1:0]  o_bresp;
   reg_addr_t   i_araddr;
   logic        i_arvalid;
   logic        o_arready;
   logic        o_rvalid;
   logic        i_rready;
   logic [31:0] o_rdata;
   logic [1:0]  o_rresp;
   logic        i_pps;
   logic [7:0]  i_clock_status;
   sfp_pins_t   i_sfp0_pins;
   sfp_pins_t   i_sfp1_pins;
   logic [1:0]  o_leds;
   logic [3:0]  o_sw_rst;
   logic [7:0]  o_clock_control;
   reg_data_t   o_ref_freq;
   logic        o_ref_freq_changed;
   logic [1:0]  o_sfp0_rs_drive_low;
   logic [1:0]  o_sfp1_rs_drive_low;
   logic [23:0] o_fp_gpio_src;

   logic [15:0] lfsr_state;
   int          freq_pulses = 0;

   ctrl_bus_top #(.SYNC_STAGES(SYNC_STAGES)) UUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Change pulse counted away from the active edge
   always @(negedge clk)
      if (!i_reset && o_ref_freq_changed)
         freq_pulses++;

   // ------------------------------------------------------------
   // Checks and failure handling
   task automatic abort_run(input string reason);
      $display("SOME TESTS FAILED");
      $fatal(1, reason);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected) else begin
         $display("ERROR at time %0t: %s expected 0x%0h, actual 0x%0h",
                  $time, name, expected, actual);
         abort_run("value mismatch");
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("Check failed at time %0t: %s", $time, what);
         abort_run("check failed");
      end
   endtask

   task automatic timed_out(input string what);
      $display("Timeout at time %0t while waiting for %s", $time, what);
      abort_run("timeout");
   endtask

   // 16-bit Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0] value;
      logic        feedback;
      value = '0;
      for (int i = 0; i < count; i++) begin
         feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], feedback};
         value      = {value[30:0], feedback};
      end
      return value;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   // ------------------------------------------------------------
   // AXI4-Lite host accesses
   task automatic axil_write(input reg_addr_t addr, input reg_data_t data, input int hold);
      int wait_count;
      wait_count = 0;
      i_awaddr   = addr;
      i_wdata    = data;
      i_awvalid  = 1'b1;
      i_wvalid   = 1'b1;
      #1;
      while (!o_awready) begin
         next_cycle();
         wait_count++;
         if (wait_count > TIMEOUT)
            timed_out("awready");
      end
      check_true(o_wready, "wready rises with awready");
      next_cycle();
      i_awvalid  = 1'b0;
      i_wvalid   = 1'b0;
      wait_count = 0;
      while (!o_bvalid) begin
         next_cycle();
         wait_count++;
         if (wait_count > TIMEOUT)
            timed_out("bvalid");
      end
      check_value("o_bresp", 64'(2'b00), 64'(o_bresp));
      // A read offered now must wait for the response
      i_arvalid = 1'b1;
      for (int i = 0; i < hold; i++) begin
         next_cycle();
         check_value("o_bvalid", 64'(1'b1), 64'(o_bvalid));
         check_value("o_arready", 64'(1'b0), 64'(o_arready));
      end
      i_arvalid = 1'b0;
      i_bready  = 1'b1;
      next_cycle();
      i_bready  = 1'b0;
      check_value("o_bvalid", 64'(1'b0), 64'(o_bvalid));
   endtask

   task automatic axil_read(input reg_addr_t addr, input int hold, output reg_data_t data);
      int wait_count;
      wait_count = 0;
      i_araddr   = addr;
      i_arvalid  = 1'b1;
      #1;
      while (!o_arready) begin
         next_cycle();
         wait_count++;
         if (wait_count > TIMEOUT)
            timed_out("arready");
      end
      next_cycle();
      i_arvalid  = 1'b0;
      wait_count = 0;
      while (!o_rvalid) begin
         next_cycle();
         wait_count++;
         if (wait_count > TIMEOUT)
            timed_out("rvalid");
      end
      data = o_rdata;
      check_value("o_rresp", 64'(2'b00), 64'(o_rresp));
      // An unmapped write offered under back-pressure is never accepted
      i_awaddr  = 8'hF0;
      i_wdata   = '0;
      i_awvalid = 1'b1;
      i_wvalid  = 1'b1;
      for (int i = 0; i < hold; i++) begin
         next_cycle();
         check_value("o_rvalid", 64'(1'b1), 64'(o_rvalid));
         check_value("o_rdata", 64'(data), 64'(o_rdata));
         check_value("o_awready", 64'(1'b0), 64'(o_awready));
      end
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      i_rready  = 1'b1;
      next_cycle();
      i_rready  = 1'b0;
      check_value("o_rvalid", 64'(1'b0), 64'(o_rvalid));
   endtask

   task automatic expect_read(input string name, input reg_addr_t addr,
                              input reg_data_t expected);
      reg_data_t word;
      axil_read(addr, int'(take_bits(2)), word);
      check_value(name, 64'(expected), 64'(word));
   endtask

   task automatic read_wide(input reg_addr_t lo_addr, input reg_addr_t hi_addr,
                            output logic [63:0] value);
      reg_data_t lo;
      reg_data_t hi;
      axil_read(lo_addr, int'(take_bits(2)), lo);
      axil_read(hi_addr, int'(take_bits(2)), hi);
      value = {hi, lo};
   endtask

   // ------------------------------------------------------------
   // Test sequence
   initial begin
      reg_data_t   data;
      reg_data_t   word;
      reg_data_t   gpio_data;
      reg_data_t   device_data;
      reg_data_t   c1;
      reg_data_t   c2;
      reg_data_t   c3;
      logic [63:0] t1;
      logic [63:0] t2;
      logic [63:0] pps;
      logic [73:0] outs_before;
      int          pulses_before;
      int          wait_count;

      lfsr_state     = 16'd39987;
      i_reset        = 1'b1;
      i_awaddr       = '0;
      i_awvalid      = 1'b0;
      i_wdata        = '0;
      i_wvalid       = 1'b0;
      i_bready       = 1'b0;
      i_araddr       = '0;
      i_arvalid      = 1'b0;
      i_rready       = 1'b0;
      i_pps          = 1'b0;
      i_clock_status = '0;
      i_sfp0_pins    = '0;
      i_sfp1_pins    = '0;
      repeat (16) next_cycle();
      i_reset = 1'b0;
      next_cycle();

      // Reset values
      check_value("o_clock_control", 64'(8'h40), 64'(o_clock_control));
      check_value("o_ref_freq", 64'(32'd10_000_000), 64'(o_ref_freq));
      check_value("o_leds", 64'(0), 64'(o_leds));
      check_value("o_sw_rst", 64'(0), 64'(o_sw_rst));
      check_value("o_fp_gpio_src", 64'(0), 64'(o_fp_gpio_src));
      check_value("o_sfp0_rs_drive_low", 64'(0), 64'(o_sfp0_rs_drive_low));
      check_value("o_sfp1_rs_drive_low", 64'(0), 64'(o_sfp1_rs_drive_low));
      expect_read("o_rdata at RB_COMPAT_NUM", RB_COMPAT_NUM, 32'h0027_0002);

      // Setting registers truncated to their widths
      data = take_bits(32);
      axil_write(SR_LEDS, data, int'(take_bits(2)));
      check_value("o_leds", 64'(data[1:0]), 64'(o_leds));
      data = take_bits(32);
      axil_write(SR_SW_RST, data, int'(take_bits(2)));
      check_value("o_sw_rst", 64'(data[3:0]), 64'(o_sw_rst));
      data = take_bits(32);
      axil_write(SR_CLOCK_CTRL, data, int'(take_bits(2)));
      check_value("o_clock_control", 64'(data[7:0]), 64'(o_clock_control));
      data = take_bits(32);
      axil_write(SR_SFPP_CTRL0, data, int'(take_bits(2)));
      check_value("o_sfp0_rs_drive_low", 64'(data[1:0]), 64'(o_sfp0_rs_drive_low));
      data = take_bits(32);
      axil_write(SR_SFPP_CTRL1, data, int'(take_bits(2)));
      check_value("o_sfp1_rs_drive_low", 64'(data[1:0]), 64'(o_sfp1_rs_drive_low));
      gpio_data = take_bits(32);
      axil_write(SR_FP_GPIO_SRC, gpio_data, int'(take_bits(2)));
      check_value("o_fp_gpio_src", 64'(gpio_data[23:0]), 64'(o_fp_gpio_src));
      expect_read("o_rdata at RB_FP_GPIO_SRC", RB_FP_GPIO_SRC, {8'd0, gpio_data[23:0]});
      device_data = take_bits(32);
      axil_write(SR_DEVICE_ID, device_data, int'(take_bits(2)));
      expect_read("o_rdata at RB_DEVICE_ID", RB_DEVICE_ID, {16'd0, device_data[15:0]});

      pulses_before = freq_pulses;
      data = take_bits(32);
      axil_write(SR_REF_FREQ, data, int'(take_bits(2)));
      check_value("o_ref_freq", 64'(data), 64'(o_ref_freq));
      check_value("o_ref_freq_changed cycles", 64'(1), 64'(freq_pulses - pulses_before));

      // Unmapped settings addresses
      outs_before = {o_leds, o_sw_rst, o_clock_control, o_ref_freq,
                     o_sfp0_rs_drive_low, o_sfp1_rs_drive_low, o_fp_gpio_src};
      pulses_before = freq_pulses;
      axil_write(8'd5, take_bits(32), int'(take_bits(2)));
      axil_write(8'hFF, take_bits(32), int'(take_bits(2)));
      check_true(outs_before == {o_leds, o_sw_rst, o_clock_control, o_ref_freq,
                                 o_sfp0_rs_drive_low, o_sfp1_rs_drive_low, o_fp_gpio_src},
                 "unmapped writes leave all setting outputs unchanged");
      check_value("o_ref_freq_changed cycles", 64'(0), 64'(freq_pulses - pulses_before));
      expect_read("o_rdata at RB_DEVICE_ID", RB_DEVICE_ID, {16'd0, device_data[15:0]});

      i_clock_status = 8'(take_bits(8));
      expect_read("o_rdata at RB_CLK_STATUS", RB_CLK_STATUS, {24'd0, i_clock_status});

      // SFP sticky flags
      // Changed flags sit in bits 5:3 and now flags in bits 2:0
      axil_read(RB_SFPP_STATUS0, 0, word);
      axil_read(RB_SFPP_STATUS1, 0, word);
      i_sfp0_pins.tx_fault = 1'b1;
      for (int i = 0; i < SYNC_STAGES + 2; i++)
         next_cycle();
      expect_read("o_rdata at RB_SFPP_STATUS0", RB_SFPP_STATUS0, 32'h0000_0012);
      expect_read("o_rdata at RB_SFPP_STATUS0", RB_SFPP_STATUS0, 32'h0000_0002);
      expect_read("o_rdata at RB_SFPP_STATUS1", RB_SFPP_STATUS1, 32'h0000_0000);

      // Counter and time
      axil_read(RB_COUNTER, int'(take_bits(2)), c1);
      axil_read(RB_COUNTER, int'(take_bits(2)), c2);
      check_true(c2 > c1, "counter increases between reads");
      read_wide(RB_TIME_LO, RB_TIME_HI, t1);
      check_true(t1 > {32'd0, c2}, "time is above the earlier counter value");
      axil_read(RB_COUNTER, int'(take_bits(2)), c3);
      check_true(t1 < {32'd0, c3}, "time is below the later counter value");

      // PPS capture
      i_pps = 1'b1;
      repeat (4) next_cycle();
      i_pps = 1'b0;
      wait_count = 0;
      word = '0;
      while (word == '0) begin
         axil_read(RB_PPS_LO, 0, word);
         wait_count++;
         if (wait_count > TIMEOUT)
            timed_out("last PPS capture");
      end
      axil_read(RB_PPS_HI, int'(take_bits(2)), data);
      pps = {data, word};
      check_true(pps > t1, "last PPS time is after the earlier time read");
      read_wide(RB_TIME_LO, RB_TIME_HI, t2);
      check_true(pps <= t2, "last PPS time is not above the following time read");

      // Long back-pressure on both response channels
      data = take_bits(32);
      axil_write(SR_LEDS, data, 6);
      check_value("o_leds", 64'(data[1:0]), 64'(o_leds));
      axil_read(RB_FP_GPIO_SRC, 7, word);
      check_value("o_rdata at RB_FP_GPIO_SRC", 64'({8'd0, gpio_data[23:0]}), 64'(word));

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/bus_map_pkg.sv
rtl/board_status_pkg.sv
rtl/axil_bus_fsm.sv
rtl/timekeeper.sv
rtl/setting_regs.sv
rtl/sfp_status.sv
rtl/readback_mux.sv
rtl/ctrl_bus_top.sv
testbench/ctrl_bus_tb.sv

// ==== Makefile ====
# Verilator flow for the board control hub
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= ctrl_bus_tb
RTL_TOP   ?= ctrl_bus_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
